//--- bench/uartTrace.txt
// One hex word per operation: op, offset, data, count (count bit 7 sends bad parity)
// Ops: 1 write, 2 read and compare, 3 poll LSR for mask, 4 send on SIN, 5 expect on SOUT
// Reset values
256001
230001
240001
210001
270001
// Divisor of 2 through DLAB, then odd parity and plain registers
138001
100201
110001
200201
210001
130801
200001
110501
210501
17A501
27A501
// Two bytes out on SOUT
10A302
50A302
304001
256001
// Loopback of three bytes
141001
104103
304001
204103
256001
140001
// Even parity, one bad frame, then seventeen frames into a 16 entry FIFO
131801
403C81
300101
203C01
256401
256001
400111
256301
200110
256001
000000

//--- vlog.f
hw/uartPkg.sv
hw/uartFifo.sv
hw/uartBaudGen.sv
hw/uartTransmitter.sv
hw/uartReceiver.sv
hw/uartRegs.sv
hw/apbUart.sv
bench/apbUart_checker.sv
bench/uartMonitor.sv
bench/tbApbUart.sv

//--- bench/tbApbUart.sv
/* Testbench for the APB UART
   Runs the trace of bus accesses and serial frames against the DUT */
`timescale 1ns/1ps

module tbApbUart;

	localparam int TraceDepth = 64;

	logic CLK = 1'b0;
	logic iRST;
	logic PSEL;
	logic PENABLE;
	logic PWRITE;
	logic [uartPkg::AddrWidth-1:0] PADDR;
	logic [uartPkg::DataWidth-1:0] PWDATA;
	logic SIN;
	logic [uartPkg::DataWidth-1:0] PRDATA;
	logic PREADY;
	logic SOUT;

	logic [23:0] trace [TraceDepth];
	logic [7:0] lcrShadow;
	logic [7:0] dllShadow;
	logic [7:0] dlmShadow;
	int readErrors;
	int serialErrors;
	int txSeen;
	int txExpected;
	int traceErrors;
	int assertErrors;
	int limit;
	int cycleCount;

	apbUart i_apbUart (
		.CLK(CLK), .iRST(iRST),
		.PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
		.PADDR(PADDR), .PWDATA(PWDATA), .SIN(SIN),
		.PRDATA(PRDATA), .PREADY(PREADY), .SOUT(SOUT)
	);

	uartMonitor i_uartMonitor (
		.CLK(CLK), .iRST(iRST),
		.PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
		.PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA), .SOUT(SOUT),
		.readErrors(readErrors), .serialErrors(serialErrors), .txSeen(txSeen)
	);

	always #5 CLK = ~CLK;

	function automatic int bitCycles(logic [7:0] msb, logic [7:0] lsb);
		int div;
		div = {msb, lsb};
		if (div < 2)
			div = 1;
		return div * uartPkg::OversampleRate;
	endfunction

	// Even count of ones with EPS set, odd count otherwise
	function automatic logic parityFor(logic [7:0] data, logic even);
		int ones;
		ones = $countones(data);
		return even ? ones[0] : !ones[0];
	endfunction

	// Cycle budget where each operation may cost one longest frame
	function automatic int runBudget();
		logic [7:0] lcr;
		logic [7:0] dll;
		logic [7:0] dlm;
		int ops;
		int maxBit;
		int n;
		lcr = '0;
		dll = '0;
		dlm = '0;
		ops = 0;
		maxBit = bitCycles(8'h00, 8'h01);
		for (n = 0; n < TraceDepth; n++)
		begin
			if (trace[n][23:20] == 4'h0)
				break;
			ops += (trace[n][6:0] == 7'd0) ? 1 : int'(trace[n][6:0]);
			if (trace[n][23:20] == 4'h1)
			begin
				if (trace[n][18:16] == uartPkg::RegLcr)
					lcr = trace[n][15:8];
				else if (trace[n][18:16] == uartPkg::RegThrRbrDll && lcr[uartPkg::LcrDlab])
					dll = trace[n][15:8];
				else if (trace[n][18:16] == uartPkg::RegIerDlm && lcr[uartPkg::LcrDlab])
					dlm = trace[n][15:8];
			end
			if (bitCycles(dlm, dll) > maxBit)
				maxBit = bitCycles(dlm, dll);
		end
		return ops * (11 * maxBit + 64) + 1000;
	endfunction

	task automatic idleGap();
		repeat ($urandom % 4) @(posedge CLK);
	endtask

	task automatic apbWrite(input logic [2:0] addr, input logic [7:0] data);
		@(posedge CLK);
		PSEL <= 1'b1;
		PWRITE <= 1'b1;
		PADDR <= addr;
		PWDATA <= {24'h0, data};
		@(posedge CLK);
		PENABLE <= 1'b1;
		@(posedge CLK);
		PSEL <= 1'b0;
		PENABLE <= 1'b0;
		if (addr == uartPkg::RegLcr)
			lcrShadow = data;
		else if (addr == uartPkg::RegThrRbrDll && lcrShadow[uartPkg::LcrDlab])
			dllShadow = data;
		else if (addr == uartPkg::RegIerDlm && lcrShadow[uartPkg::LcrDlab])
			dlmShadow = data;
	endtask

	task automatic apbRead(input logic [2:0] addr, output logic [7:0] data);
		@(posedge CLK);
		PSEL <= 1'b1;
		PWRITE <= 1'b0;
		PADDR <= addr;
		@(posedge CLK);
		PENABLE <= 1'b1;
		@(negedge CLK);
		data = PRDATA[7:0];
		@(posedge CLK);
		PSEL <= 1'b0;
		PENABLE <= 1'b0;
	endtask

	task automatic driveBit(input logic level);
		SIN <= level;
		repeat (bitCycles(dlmShadow, dllShadow)) @(posedge CLK);
	endtask

	// Start, data LSB first, optional parity, stop
	task automatic sendFrame(input logic [7:0] data, input logic badParity);
		int i;
		@(posedge CLK);
		driveBit(1'b0);
		for (i = 0; i < 8; i++)
			driveBit(data[i]);
		if (lcrShadow[uartPkg::LcrPen])
			driveBit(parityFor(data, lcrShadow[uartPkg::LcrEps]) ^ badParity);
		driveBit(1'b1);
	endtask

	task automatic runOp(input logic [23:0] entry);
		logic [3:0] op;
		logic [2:0] addr;
		logic [7:0] data;
		logic [7:0] value;
		int count;
		int k;
		op = entry[23:20];
		addr = entry[18:16];
		data = entry[15:8];
		count = (entry[6:0] == 7'd0) ? 1 : int'(entry[6:0]);
		case (op)
			4'h1:
			for (k = 0; k < count; k++)
			begin
				apbWrite(addr, data + 8'(k));
				idleGap();
			end
			4'h2:
			for (k = 0; k < count; k++)
			begin
				apbRead(addr, value);
				idleGap();
			end
			4'h3:
			begin
				value = '0;
				while ((value & data) == 8'h00)
				begin
					apbRead(uartPkg::RegLsr, value);
					idleGap();
				end
			end
			4'h4:
			for (k = 0; k < count; k++)
				sendFrame(data + 8'(k), entry[7]);
			4'h5:
			begin
				txExpected += count;
				wait (txSeen >= txExpected);
			end
			default:
			begin
				$display("Trace holds an unknown operation code %h", op);
				traceErrors++;
			end
		endcase
	endtask

	initial
	begin
		int n;
		iRST = 1'b1;
		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		PADDR = '0;
		PWDATA = '0;
		SIN = 1'b1;
		lcrShadow = '0;
		dllShadow = '0;
		dlmShadow = '0;
		txExpected = 0;
		traceErrors = 0;
		assertErrors = 0;
		limit = 0;
		void'($urandom(32'h912f));
		foreach (trace[i])
			trace[i] = '0;
		$readmemh("bench/uartTrace.txt", trace);
		limit = runBudget();
		repeat (10) @(posedge CLK);
		iRST <= 1'b0;
		for (n = 0; n < TraceDepth; n++)
		begin
			if (trace[n][23:20] == 4'h0)
				break;
			runOp(trace[n]);
		end
		repeat (50) @(posedge CLK);
		assertErrors = i_apbUart.i_apbUartChecker.assertFailures;
		$display("Errors: %0d read, %0d serial, %0d trace, %0d assertion",
			readErrors, serialErrors, traceErrors, assertErrors);
		if (readErrors + serialErrors + traceErrors + assertErrors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		cycleCount = 0;
		wait (limit > 0);
		while (cycleCount < limit)
		begin
			@(posedge CLK);
			cycleCount++;
		end
		$display("Timeout after %0d cycles with the trace unfinished (%0d read, %0d serial errors)",
			limit, readErrors, serialErrors);
		$display("Testbench failed");
		$finish;
	end

endmodule

//--- bench/uartMonitor.sv
/* UART monitor
   Compares APB reads and decoded SOUT frames with the trace expectations */
`timescale 1ns/1ps

module uartMonitor (
	input  logic                          CLK,
	input  logic                          iRST,
	input  logic                          PSEL,
	input  logic                          PENABLE,
	input  logic                          PWRITE,
	input  logic [uartPkg::AddrWidth-1:0] PADDR,
	input  logic [uartPkg::DataWidth-1:0] PWDATA,
	input  logic [uartPkg::DataWidth-1:0] PRDATA,
	input  logic                          SOUT,
	output int                            readErrors,
	output int                            serialErrors,
	output int                            txSeen
);

	logic [23:0] trace [64];
	logic [7:0] rdValue [$];
	logic rdPoll [$];
	logic [7:0] txValue [$];
	logic [7:0] lcr = '0;
	logic [7:0] dll = '0;
	logic [7:0] dlm = '0;
	int rdErr = 0;
	int serErr = 0;
	int seen = 0;

	assign readErrors = rdErr;
	assign serialErrors = serErr;
	assign txSeen = seen;

	function automatic int bitCycles(logic [7:0] msb, logic [7:0] lsb);
		int div;
		div = {msb, lsb};
		if (div < 2)
			div = 1;
		return div * uartPkg::OversampleRate;
	endfunction

	// Even count of ones with EPS set, odd count otherwise
	function automatic logic parityFor(logic [7:0] data, logic even);
		int ones;
		ones = $countones(data);
		return even ? ones[0] : !ones[0];
	endfunction

	// Expand the trace into read and SOUT expectations
	initial
	begin
		int n;
		int k;
		int count;
		logic [7:0] data;
		foreach (trace[i])
			trace[i] = '0;
		$readmemh("bench/uartTrace.txt", trace);
		for (n = 0; n < 64; n++)
		begin
			if (trace[n][23:20] == 4'h0)
				break;
			data = trace[n][15:8];
			count = (trace[n][6:0] == 7'd0) ? 1 : int'(trace[n][6:0]);
			for (k = 0; k < count; k++)
			begin
				case (trace[n][23:20])
					4'h2:
					begin
						rdValue.push_back(data + 8'(k));
						rdPoll.push_back(1'b0);
					end
					4'h3:
					begin
						rdValue.push_back(data);
						rdPoll.push_back(1'b1);
					end
					4'h5: txValue.push_back(data + 8'(k));
					default: ;
				endcase
			end
		end
	end

	always @(negedge CLK)
	begin
		if (!iRST && PSEL && PENABLE && PWRITE)
		begin
			// Shadow the registers that shape the serial frame
			if (PADDR == uartPkg::RegLcr)
				lcr = PWDATA[7:0];
			else if (PADDR == uartPkg::RegThrRbrDll && lcr[uartPkg::LcrDlab])
				dll = PWDATA[7:0];
			else if (PADDR == uartPkg::RegIerDlm && lcr[uartPkg::LcrDlab])
				dlm = PWDATA[7:0];
		end
		else if (!iRST && PSEL && PENABLE)
		begin
			if (rdValue.size() == 0)
			begin
				$display("APB read at offset %0d was not expected by the trace", PADDR);
				rdErr++;
			end
			else if (rdPoll[0])
			begin
				if ((PRDATA[7:0] & rdValue[0]) != 8'h00)
				begin
					void'(rdValue.pop_front());
					void'(rdPoll.pop_front());
				end
			end
			else
			begin
				if (PRDATA !== {24'h0, rdValue[0]})
				begin
					$display("[ERROR] PRDATA at offset %0d: expected %h, got %h",
						PADDR, {24'h0, rdValue[0]}, PRDATA);
					rdErr++;
				end
				void'(rdValue.pop_front());
				void'(rdPoll.pop_front());
			end
		end
	end

	task automatic checkFrame(input logic [7:0] data, input logic parityBit, input logic stopBit);
		logic [7:0] expected;
		if (txValue.size() == 0)
		begin
			$display("Frame %h on SOUT was not expected by the trace", data);
			serErr++;
		end
		else
		begin
			expected = txValue.pop_front();
			if (data !== expected)
			begin
				$display("[ERROR] SOUT data: expected %h, got %h", expected, data);
				serErr++;
			end
			if (lcr[uartPkg::LcrPen] && parityBit !== parityFor(expected, lcr[uartPkg::LcrEps]))
			begin
				$display("[ERROR] SOUT parity: expected %h, got %h",
					parityFor(expected, lcr[uartPkg::LcrEps]), parityBit);
				serErr++;
			end
			if (stopBit !== 1'b1)
			begin
				$display("[ERROR] SOUT stop bit: expected 1, got %h", stopBit);
				serErr++;
			end
			seen++;
		end
	endtask

	// Frame decoder that samples each bit at its middle
	always
	begin : decodeSout
		logic [7:0] data;
		logic parityBit;
		logic stopBit;
		int bitTime;
		int i;
		@(negedge CLK);
		if (!iRST && SOUT === 1'b0)
		begin
			bitTime = bitCycles(dlm, dll);
			repeat (bitTime / 2) @(negedge CLK);
			if (SOUT !== 1'b0)
			begin
				$display("Start bit on SOUT ended before the middle of the bit");
				serErr++;
			end
			else
			begin
				for (i = 0; i < 8; i++)
				begin
					repeat (bitTime) @(negedge CLK);
					data[i] = SOUT;
				end
				parityBit = 1'b0;
				if (lcr[uartPkg::LcrPen])
				begin
					repeat (bitTime) @(negedge CLK);
					parityBit = SOUT;
				end
				repeat (bitTime) @(negedge CLK);
				stopBit = SOUT;
				checkFrame(data, parityBit, stopBit);
			end
		end
	end

endmodule

//--- bench/apbUart_checker.sv
/* Protocol assertions for the APB UART, bound into the top level */
`timescale 1ns/1ps

module apbUart_checker (
	input logic                              CLK,
	input logic                              iRST,
	input logic                              SOUT,
	input logic                              PREADY,
	input logic                              txFull,
	input logic [uartPkg::FifoAddrWidth-1:0] txWrPtr,
	input logic                              overrun,
	input logic                              oeFlag
);

	int assertFailures = 0;

	// Serial line idles high through reset
	soutHighInReset: assert property (@(posedge CLK) iRST |-> SOUT)
		else
		begin
			assertFailures++;
			$error("SOUT low while reset is asserted");
		end

	// A full TX FIFO keeps its write pointer where it is
	txNoPushWhenFull: assert property (@(posedge CLK) disable iff (iRST)
		txFull |=> $stable(txWrPtr))
		else
		begin
			assertFailures++;
			$error("TX FIFO pushed while full");
		end

	preadyAlwaysHigh: assert property (@(posedge CLK) PREADY === 1'b1)
		else
		begin
			assertFailures++;
			$error("PREADY went low");
		end

	// OE follows a receiver overrun by one cycle
	oeOnlyOnOverrun: assert property (@(posedge CLK) disable iff (iRST)
		$rose(oeFlag) |-> $past(overrun))
		else
		begin
			assertFailures++;
			$error("OE set without a receiver overrun");
		end

endmodule

bind apbUart apbUart_checker i_apbUartChecker (
	.CLK(CLK), .iRST(iRST), .SOUT(SOUT), .PREADY(PREADY),
	.txFull(txFull), .txWrPtr(i_txFifo.wrPtr), .overrun(overrun),
	.oeFlag(i_uartRegs.lsrOe)
);

//--- hw/apbUart.sv
/* APB UART top level
   Connects registers, baud generator, FIFOs, transmitter, receiver and loopback */
`timescale 1ns/1ps

module apbUart (
	input  logic                          CLK,
	input  logic                          iRST,
	input  logic                          PSEL,
	input  logic                          PENABLE,
	input  logic                          PWRITE,
	input  logic [uartPkg::AddrWidth-1:0] PADDR,
	input  logic [uartPkg::DataWidth-1:0] PWDATA,
	input  logic                          SIN,
	output logic [uartPkg::DataWidth-1:0] PRDATA,
	output logic                          PREADY,
	output logic                          SOUT
);

	logic thrWrite;
	uartPkg::txByteT thrData;
	logic rbrPop;
	logic [uartPkg::DivWidth-1:0] divisor;
	logic divRestart;
	logic parityEn;
	logic evenParity;
	logic loopback;
	logic tick16;
	uartPkg::txByteT txHead;
	logic txEmpty;
	logic txFull;
	logic txPop;
	logic txBusy;
	logic txOut;
	uartPkg::rxEntryT rxEntry;
	uartPkg::rxEntryT rxHead;
	logic rxEmpty;
	logic rxFull;
	logic rxPush;
	logic overrun;
	logic rxIn;

	assign PREADY = 1'b1;

	// Loopback feeds the transmitter straight into the receiver
	assign rxIn = loopback ? txOut : SIN;

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
			SOUT <= 1'b1;
		else
			SOUT <= loopback ? 1'b1 : txOut;
	end

	uartRegs i_uartRegs (
		.CLK(CLK), .iRST(iRST),
		.PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
		.PADDR(PADDR), .PWDATA(PWDATA),
		.rxEntry(rxHead), .rxEmpty(rxEmpty),
		.txFull(txFull), .txEmpty(txEmpty), .txBusy(txBusy),
		.overrun(overrun), .PRDATA(PRDATA),
		.thrWrite(thrWrite), .thrData(thrData), .rbrPop(rbrPop),
		.divisor(divisor), .divRestart(divRestart),
		.parityEn(parityEn), .evenParity(evenParity), .loopback(loopback)
	);

	uartBaudGen i_uartBaudGen (
		.CLK(CLK), .iRST(iRST),
		.divisor(divisor), .restart(divRestart), .tick16(tick16)
	);

	uartFifo #(.payloadT(uartPkg::txByteT)) i_txFifo (
		.CLK(CLK), .iRST(iRST), .clear(1'b0),
		.push(thrWrite), .pop(txPop), .wrData(thrData),
		.rdData(txHead), .empty(txEmpty), .full(txFull)
	);

	uartFifo #(.payloadT(uartPkg::rxEntryT)) i_rxFifo (
		.CLK(CLK), .iRST(iRST), .clear(1'b0),
		.push(rxPush), .pop(rbrPop), .wrData(rxEntry),
		.rdData(rxHead), .empty(rxEmpty), .full(rxFull)
	);

	uartTransmitter i_uartTransmitter (
		.CLK(CLK), .iRST(iRST), .tick16(tick16),
		.parityEn(parityEn), .evenParity(evenParity),
		.fifoEmpty(txEmpty), .txData(txHead),
		.fifoPop(txPop), .busy(txBusy), .txOut(txOut)
	);

	uartReceiver i_uartReceiver (
		.CLK(CLK), .iRST(iRST), .tick16(tick16),
		.parityEn(parityEn), .evenParity(evenParity),
		.rxIn(rxIn), .fifoFull(rxFull),
		.fifoPush(rxPush), .rxEntry(rxEntry), .overrun(overrun)
	);

endmodule

//--- hw/uartRegs.sv
/* APB register file of the UART
   Decodes accesses, holds control registers and LSR flags, drives read data */
`timescale 1ns/1ps

module uartRegs (
	input  logic                          CLK,
	input  logic                          iRST,
	input  logic                          PSEL,
	input  logic                          PENABLE,
	input  logic                          PWRITE,
	input  logic [uartPkg::AddrWidth-1:0] PADDR,
	input  logic [uartPkg::DataWidth-1:0] PWDATA,
	input  uartPkg::rxEntryT              rxEntry,
	input  logic                          rxEmpty,
	input  logic                          txFull,
	input  logic                          txEmpty,
	input  logic                          txBusy,
	input  logic                          overrun,
	output logic [uartPkg::DataWidth-1:0] PRDATA,
	output logic                          thrWrite,
	output uartPkg::txByteT               thrData,
	output logic                          rbrPop,
	output logic [uartPkg::DivWidth-1:0]  divisor,
	output logic                          divRestart,
	output logic                          parityEn,
	output logic                          evenParity,
	output logic                          loopback
);

	logic [uartPkg::ByteWidth-1:0] dll;
	logic [uartPkg::ByteWidth-1:0] dlm;
	logic [uartPkg::ByteWidth-1:0] ier;
	logic [uartPkg::ByteWidth-1:0] lcr;
	logic [uartPkg::ByteWidth-1:0] mcr;
	logic [uartPkg::ByteWidth-1:0] scr;
	logic [uartPkg::ByteWidth-1:0] lsr;
	logic [uartPkg::ByteWidth-1:0] rdByte;
	logic [uartPkg::ByteWidth-1:0] wrByte;
	logic lsrOe;
	logic lsrPe;
	logic dlab;
	logic busWrite;
	logic busRead;
	logic dllWrite;
	logic dlmWrite;
	logic lsrRead;

	assign busWrite = PSEL && PENABLE && PWRITE;
	assign busRead = PSEL && PENABLE && !PWRITE;
	assign wrByte = PWDATA[uartPkg::ByteWidth-1:0];
	assign dlab = lcr[uartPkg::LcrDlab];

	// Offsets 0 and 1 switch to the divisor latches with DLAB
	assign thrWrite = busWrite && (PADDR == uartPkg::RegThrRbrDll) && !dlab && !txFull;
	assign dllWrite = busWrite && (PADDR == uartPkg::RegThrRbrDll) && dlab;
	assign dlmWrite = busWrite && (PADDR == uartPkg::RegIerDlm) && dlab;
	assign rbrPop = busRead && (PADDR == uartPkg::RegThrRbrDll) && !dlab && !rxEmpty;
	assign lsrRead = busRead && (PADDR == uartPkg::RegLsr);

	assign thrData = wrByte;
	assign divisor = {dlm, dll};
	assign divRestart = dllWrite || dlmWrite;
	assign parityEn = lcr[uartPkg::LcrPen];
	assign evenParity = lcr[uartPkg::LcrEps];
	assign loopback = mcr[uartPkg::McrLoop];

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			dll <= '0;
			dlm <= '0;
			ier <= '0;
			lcr <= '0;
			mcr <= '0;
			scr <= '0;
		end
		else if (busWrite)
		begin
			if (dllWrite)
				dll <= wrByte;
			if (dlmWrite)
				dlm <= wrByte;
			if (PADDR == uartPkg::RegIerDlm && !dlab)
				ier <= wrByte;
			if (PADDR == uartPkg::RegLcr)
				lcr <= wrByte;
			if (PADDR == uartPkg::RegMcr)
				mcr <= wrByte;
			if (PADDR == uartPkg::RegScr)
				scr <= wrByte;
		end
	end

	// Sticky error flags where a new event wins over the clearing read
	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			lsrOe <= 1'b0;
			lsrPe <= 1'b0;
		end
		else
		begin
			if (overrun)
				lsrOe <= 1'b1;
			else if (lsrRead)
				lsrOe <= 1'b0;
			if (rbrPop && rxEntry.parityErr)
				lsrPe <= 1'b1;
			else if (lsrRead)
				lsrPe <= 1'b0;
		end
	end

	always_comb
	begin
		lsr = '0;
		lsr[uartPkg::LsrDr] = !rxEmpty;
		lsr[uartPkg::LsrOe] = lsrOe;
		lsr[uartPkg::LsrPe] = lsrPe;
		lsr[uartPkg::LsrThre] = txEmpty;
		lsr[uartPkg::LsrTemt] = txEmpty && !txBusy;
	end

	always_comb
	begin
		case (PADDR)
			uartPkg::RegThrRbrDll: rdByte = dlab ? dll : (rxEmpty ? '0 : rxEntry.data);
			uartPkg::RegIerDlm:    rdByte = dlab ? dlm : ier;
			uartPkg::RegLcr:       rdByte = lcr;
			uartPkg::RegMcr:       rdByte = mcr;
			uartPkg::RegLsr:       rdByte = lsr;
			uartPkg::RegScr:       rdByte = scr;
			default:               rdByte = '0;
		endcase
	end

	assign PRDATA = {{(uartPkg::DataWidth-uartPkg::ByteWidth){1'b0}}, rdByte};

endmodule

//--- hw/uartReceiver.sv
/* UART receiver
   Synchronizes the line, samples mid-bit, checks parity and pushes to the RX FIFO */
`timescale 1ns/1ps

module uartReceiver (
	input  logic             CLK,
	input  logic             iRST,
	input  logic             tick16,
	input  logic             parityEn,
	input  logic             evenParity,
	input  logic             rxIn,
	input  logic             fifoFull,
	output logic             fifoPush,
	output uartPkg::rxEntryT rxEntry,
	output logic             overrun
);

	typedef enum logic [2:0] {RxIdle, RxStart, RxData, RxParity, RxStop} stateT;

	stateT state;
	logic [1:0] rxSync;
	logic rxPrev;
	logic rxBit;
	logic [uartPkg::TickWidth-1:0] tickCnt;
	logic [uartPkg::BitCntWidth-1:0] bitCnt;
	logic [uartPkg::ByteWidth-1:0] shiftReg;
	logic parityErr;
	logic sampleNow;

	assign rxBit = rxSync[1];

	// The start bit is checked half a bit after the edge, later bits a full bit apart
	assign sampleNow = (state != RxIdle) && tick16 &&
		(tickCnt == ((state == RxStart) ? uartPkg::SampleLast : uartPkg::TickLast));

	assign rxEntry.data = shiftReg;
	assign rxEntry.parityErr = parityErr;

	// Two-flop synchronizer plus edge history
	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			rxSync <= 2'b11;
			rxPrev <= 1'b1;
		end
		else
		begin
			rxSync <= {rxSync[0], rxIn};
			rxPrev <= rxBit;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (sampleNow && state == RxStart)
			parityErr <= 1'b0;
		if (sampleNow && state == RxData)
			shiftReg <= {rxBit, shiftReg[uartPkg::ByteWidth-1:1]};
		// Error when the total count of ones breaks the selected rule
		if (sampleNow && state == RxParity)
			parityErr <= (((^shiftReg) ^ rxBit) == evenParity);
	end

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			state <= RxIdle;
			tickCnt <= '0;
			bitCnt <= '0;
			fifoPush <= 1'b0;
			overrun <= 1'b0;
		end
		else
		begin
			fifoPush <= 1'b0;
			overrun <= 1'b0;
			if (state == RxIdle)
			begin
				if (rxPrev && !rxBit)
				begin
					state <= RxStart;
					tickCnt <= '0;
				end
			end
			else if (tick16)
			begin
				tickCnt <= sampleNow ? '0 : tickCnt + 1'b1;
				if (sampleNow)
				begin
					case (state)
						// False start when the line is back high
						RxStart:
						begin
							state <= rxBit ? RxIdle : RxData;
							bitCnt <= '0;
						end
						RxData:
						begin
							bitCnt <= bitCnt + 1'b1;
							if (bitCnt == uartPkg::BitLast)
								state <= parityEn ? RxParity : RxStop;
						end
						RxParity: state <= RxStop;
						default:
						begin
							state <= RxIdle;
							fifoPush <= !fifoFull;
							overrun <= fifoFull;
						end
					endcase
				end
			end
		end
	end

endmodule

//--- hw/uartTransmitter.sv
/* UART transmitter
   Pops a byte and shifts out start, 8 data bits LSB first, parity and stop */
`timescale 1ns/1ps

module uartTransmitter (
	input  logic            CLK,
	input  logic            iRST,
	input  logic            tick16,
	input  logic            parityEn,
	input  logic            evenParity,
	input  logic            fifoEmpty,
	input  uartPkg::txByteT txData,
	output logic            fifoPop,
	output logic            busy,
	output logic            txOut
);

	typedef enum logic [2:0] {TxIdle, TxStart, TxData, TxParity, TxStop} stateT;

	stateT state;
	logic [uartPkg::TickWidth-1:0] tickCnt;
	logic [uartPkg::BitCntWidth-1:0] bitCnt;
	uartPkg::txByteT shiftReg;
	logic parityBit;
	logic lineBit;
	logic bitDone;

	assign fifoPop = (state == TxIdle) && !fifoEmpty;
	assign busy = (state != TxIdle);
	assign bitDone = busy && tick16 && (tickCnt == uartPkg::TickLast);

	// Line level for the bit currently being sent
	always_comb
	begin
		case (state)
			TxStart:  lineBit = 1'b0;
			TxData:   lineBit = shiftReg[0];
			TxParity: lineBit = parityBit;
			default:  lineBit = 1'b1;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (fifoPop)
		begin
			shiftReg <= txData;
			parityBit <= (^txData) ^ !evenParity;
		end
		else if (state == TxData && bitDone)
			shiftReg <= shiftReg >> 1;
	end

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			state <= TxIdle;
			tickCnt <= '0;
			bitCnt <= '0;
			txOut <= 1'b1;
		end
		else
		begin
			// A new bit goes on the line at the first tick of each bit slot
			if (busy && tick16 && tickCnt == '0)
				txOut <= lineBit;
			if (fifoPop)
			begin
				state <= TxStart;
				tickCnt <= '0;
				bitCnt <= '0;
			end
			else if (busy && tick16)
			begin
				tickCnt <= tickCnt + 1'b1;
				if (bitDone)
				begin
					case (state)
						TxStart:  state <= TxData;
						TxData:
						begin
							bitCnt <= bitCnt + 1'b1;
							if (bitCnt == uartPkg::BitLast)
								state <= parityEn ? TxParity : TxStop;
						end
						TxParity: state <= TxStop;
						default:  state <= TxIdle;
					endcase
				end
			end
		end
	end

endmodule

//--- hw/uartBaudGen.sv
/* Baud rate generator, one-cycle 16x tick every divisor cycles */
`timescale 1ns/1ps

module uartBaudGen (
	input  logic                         CLK,
	input  logic                         iRST,
	input  logic [uartPkg::DivWidth-1:0] divisor,
	input  logic                         restart,
	output logic                         tick16
);

	logic [uartPkg::DivWidth-1:0] count;
	logic expire;

	// Expires at 1; a divisor of 0 or 1 ticks every cycle
	assign expire = (count[uartPkg::DivWidth-1:1] == '0);

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			count <= '0;
			tick16 <= 1'b0;
		end
		else if (restart)
		begin
			count <= divisor;
			tick16 <= 1'b0;
		end
		else
		begin
			tick16 <= expire;
			count <= expire ? divisor : count - 1'b1;
		end
	end

endmodule

//--- hw/uartFifo.sv
/* Synchronous FIFO with a generic payload type
   Circular buffer with count, head entry shown on rdData */
`timescale 1ns/1ps

module uartFifo #(
	parameter type payloadT = uartPkg::txByteT
) (
	input  logic    CLK,
	input  logic    iRST,
	input  logic    clear,
	input  logic    push,
	input  logic    pop,
	input  payloadT wrData,
	output payloadT rdData,
	output logic    empty,
	output logic    full
);

	payloadT mem [uartPkg::FifoDepth];
	logic [uartPkg::FifoAddrWidth-1:0] wrPtr;
	logic [uartPkg::FifoAddrWidth-1:0] rdPtr;
	logic [uartPkg::FifoAddrWidth:0] count;
	logic doPush;
	logic doPop;

	// Depth is a power of two, so the top count bit means full
	assign full = count[uartPkg::FifoAddrWidth];
	assign empty = (count == '0);
	assign doPush = push && !full;
	assign doPop = pop && !empty;
	assign rdData = mem[rdPtr];

	always_ff @(posedge CLK)
	begin
		if (doPush)
			mem[wrPtr] <= wrData;
	end

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else if (clear)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

endmodule

//--- hw/uartPkg.sv
/* UART shared definitions
   Register map, field positions, widths and FIFO payload types */
package uartPkg;

	// Bus and data widths
	localparam int AddrWidth = 3;
	localparam int DataWidth = 32;
	localparam int ByteWidth = 8;
	localparam int DivWidth = 16;

	// FIFO geometry
	localparam int FifoDepth = 16;
	localparam int FifoAddrWidth = 4;

	// Oversampling
	localparam int OversampleRate = 16;
	localparam int SampleTick = 8;
	localparam int TickWidth = 4;
	localparam int BitCntWidth = 3;
	localparam logic [TickWidth-1:0] TickLast = TickWidth'(OversampleRate - 1);
	localparam logic [TickWidth-1:0] SampleLast = TickWidth'(SampleTick - 1);
	localparam logic [BitCntWidth-1:0] BitLast = BitCntWidth'(ByteWidth - 1);

	// Register offsets
	localparam logic [AddrWidth-1:0] RegThrRbrDll = 3'd0;
	localparam logic [AddrWidth-1:0] RegIerDlm = 3'd1;
	localparam logic [AddrWidth-1:0] RegLcr = 3'd3;
	localparam logic [AddrWidth-1:0] RegMcr = 3'd4;
	localparam logic [AddrWidth-1:0] RegLsr = 3'd5;
	localparam logic [AddrWidth-1:0] RegScr = 3'd7;

	// Bit positions
	localparam int LcrPen = 3;
	localparam int LcrEps = 4;
	localparam int LcrDlab = 7;
	localparam int McrLoop = 4;
	localparam int LsrDr = 0;
	localparam int LsrOe = 1;
	localparam int LsrPe = 2;
	localparam int LsrThre = 5;
	localparam int LsrTemt = 6;

	// FIFO payloads
	typedef logic [ByteWidth-1:0] txByteT;

	typedef struct packed {
		logic parityErr;
		logic [ByteWidth-1:0] data;
	} rxEntryT;

endpackage
